// File: common/tlk_line_pkg.sv
// TLK2711 line definitions
package tlk_line_pkg;

    //////////////////////////////////////////////////
    // line word types
    //////////////////////////////////////////////////

    // low byte goes out on the line first
    typedef logic [15:0] line_word_t;

    // number of line words held in the TX FIFO
    typedef logic [15:0] line_level_t;

    typedef enum logic [3:0]
    {
        MODE_NORM     = 4'd0,
        MODE_LOOPBACK = 4'd1,
        MODE_KCODE    = 4'd2,
        MODE_TEST     = 4'd3
    } tx_mode_e;

    //////////////////////////////////////////////////
    // line characters
    //////////////////////////////////////////////////

    // comma pair
    localparam logic [7:0] COMMA_K28_5 = 8'hBC;
    localparam logic [7:0] COMMA_D5_6  = 8'hC5;

    // start of frame
    localparam logic [7:0] SOF_K27_7 = 8'hFB;
    localparam logic [7:0] SOF_K28_2 = 8'h5C;

    // end of frame
    localparam logic [7:0] EOF_K30_7 = 8'hFE;
    localparam logic [7:0] EOF_K29_7 = 8'hFD;

    // full line words, comma carries a K flag on the low byte only
    localparam line_word_t COMMA_WORD = {COMMA_D5_6, COMMA_K28_5};
    localparam line_word_t SOF_WORD   = {SOF_K28_2, SOF_K27_7};
    localparam line_word_t EOF_WORD   = {EOF_K29_7, EOF_K30_7};

endpackage

// File: common/tx_frame_pkg.sv
// TX frame layout
package tx_frame_pkg;

    // payload length in bytes
    typedef logic [15:0] byte_len_t;

    // frame index inside a file
    typedef logic [15:0] frame_num_t;

    //////////////////////////////////////////////////
    // header and sign bytes
    //////////////////////////////////////////////////

    localparam logic [7:0] FRAME_HEAD0 = 8'h16;
    localparam logic [7:0] FRAME_HEAD1 = 8'hE1;
    localparam logic [7:0] FRAME_HEAD2 = 8'h90;
    localparam logic [7:0] FRAME_HEAD3 = 8'hEB;

    // data type
    localparam logic [7:0] TX_IND   = 8'h81;
    // marks the last frame of a file
    localparam logic [7:0] FILE_END = 8'h01;

    typedef enum logic [3:0]
    {
        IDLE,
        BEGIN,
        SYNC,
        WAIT_DATA,
        SOF,
        HEAD,
        SIGN,
        FNUM,
        DLEN,
        DATA,
        CHECK,
        EOF,
        GAP
    } framer_state_e;

endpackage

// File: hdl/tx_gearbox_fifo.sv
// TX gearbox FIFO
`timescale 1ns/100ps

module tx_gearbox_fifo
#(
    parameter int DATA_WIDTH = 64,
    parameter int FIFO_DEPTH = 512
)
(
    input  logic                      clk,
    input  logic                      i_soft_reset,
    input  logic                      i_wr_en,
    input  logic [DATA_WIDTH-1:0]     i_wr_data,
    input  logic                      i_rd_en,
    output tlk_line_pkg::line_word_t  o_rd_word,
    output tlk_line_pkg::line_level_t o_line_level,
    output logic                      o_credit
);

    import tlk_line_pkg::*;

    localparam int WORD_W = $bits(line_word_t);
    localparam int HALVES = DATA_WIDTH / WORD_W;
    localparam int ADDR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);
    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(FIFO_DEPTH - 1);
    localparam logic [1:0]        LAST_HALF = 2'(HALVES - 1);

    logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];
    logic [ADDR_W-1:0]     wr_ptr;
    logic [ADDR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]      count;
    logic [1:0]            half_sel;
    logic                  last_half;
    logic                  pop;

    // circular pointer step, depth need not be a power of two
    function automatic logic [ADDR_W-1:0] next_ptr(input logic [ADDR_W-1:0] ptr);
        return (ptr == LAST_ADDR) ? '0 : ptr + 1'b1;
    endfunction

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (i_wr_en)
            mem[wr_ptr] <= i_wr_data;
    end

    // head entry shown fall-through, lowest half first
    assign o_rd_word = mem[rd_ptr][half_sel*WORD_W +: WORD_W];

    //////////////////////////////////////////////////
    // pointers, level and credits
    //////////////////////////////////////////////////

    assign last_half = (half_sel == LAST_HALF);
    // entry is freed with its last half
    assign pop = i_rd_en & last_half;

    always_ff @(posedge clk)
    begin
        if (i_soft_reset)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            half_sel <= '0;
            o_credit <= 1'b0;
        end
        else
        begin
            if (i_wr_en)
                wr_ptr <= next_ptr(wr_ptr);
            if (i_rd_en)
                half_sel <= last_half ? 2'd0 : half_sel + 2'd1;
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            count    <= count + CNT_W'(i_wr_en) - CNT_W'(pop);
            o_credit <= pop;
        end
    end

    // halves already taken from the head entry no longer count
    assign o_line_level = line_level_t'(count * HALVES - half_sel);

endmodule

// File: tx_framer/tx_framer.sv
// TLK2711 normal-mode framer
`timescale 1ns/100ps

module tx_framer
#(
    parameter int SYNC_CYCLES = 100000,
    parameter int GAP_CYCLES  = 257
)
(
    input  logic                      clk,
    input  logic                      i_soft_reset,
    input  tlk_line_pkg::tx_mode_e    i_tx_mode,
    input  logic                      i_tx_start,
    input  tx_frame_pkg::byte_len_t   i_tx_packet_body,
    input  tx_frame_pkg::byte_len_t   i_tx_packet_tail,
    input  tx_frame_pkg::frame_num_t  i_tx_body_num,
    input  tlk_line_pkg::line_level_t i_line_level,
    input  tlk_line_pkg::line_word_t  i_rd_word,
    output logic                      o_rd_en,
    output tlk_line_pkg::line_word_t  o_txd,
    output logic                      o_tk_msb,
    output logic                      o_tk_lsb,
    output logic                      o_tx_interrupt
);

    import tlk_line_pkg::*;
    import tx_frame_pkg::*;

    localparam int SYNC_W = $clog2(SYNC_CYCLES + 1);
    localparam int GAP_W  = $clog2(GAP_CYCLES + 1);
    localparam logic [SYNC_W-1:0] SYNC_LAST = SYNC_W'(SYNC_CYCLES - 1);
    localparam logic [GAP_W-1:0]  GAP_LAST  = GAP_W'(GAP_CYCLES - 1);

    framer_state_e     state;
    framer_state_e     state_nxt;
    frame_num_t        frame_cnt;
    byte_len_t         valid_dlen;
    byte_len_t         next_dlen;
    byte_len_t         data_words;
    byte_len_t         data_cnt;
    byte_len_t         chk_cnt;
    logic [SYNC_W-1:0] sync_cnt;
    logic [GAP_W-1:0]  gap_cnt;
    logic              head_sel;
    logic              last_frame;
    logic              next_last;
    logic              gap_done;
    logic [1:0]        irq_dly;
    line_word_t        txd_nxt;
    logic              tk_msb_nxt;
    logic              tk_lsb_nxt;

    // length of the frame about to start
    assign next_last  = (frame_cnt == i_tx_body_num);
    assign next_dlen  = next_last ? i_tx_packet_tail : i_tx_packet_body;
    assign data_words = valid_dlen >> 1;
    assign gap_done   = (state == GAP) && (gap_cnt == GAP_LAST);
    assign o_rd_en    = (state == DATA);

    //////////////////////////////////////////////////
    // next state and line word
    //////////////////////////////////////////////////

    always_comb
    begin
        state_nxt  = state;
        txd_nxt    = '0;
        tk_msb_nxt = 1'b0;
        tk_lsb_nxt = 1'b0;
        case (state)
            IDLE:
            begin
                if (i_tx_start)
                    state_nxt = BEGIN;
            end
            BEGIN:
                state_nxt = SYNC;
            SYNC, WAIT_DATA, GAP:
            begin
                txd_nxt    = COMMA_WORD;
                tk_lsb_nxt = 1'b1;
                if (state == SYNC && sync_cnt == SYNC_LAST)
                    state_nxt = WAIT_DATA;
                // whole frame body must be buffered, data goes out without stalls
                if (state == WAIT_DATA && i_line_level >= (next_dlen >> 1))
                    state_nxt = SOF;
                if (gap_done)
                    state_nxt = last_frame ? IDLE : WAIT_DATA;
            end
            SOF:
            begin
                txd_nxt    = SOF_WORD;
                tk_msb_nxt = 1'b1;
                tk_lsb_nxt = 1'b1;
                state_nxt  = HEAD;
            end
            HEAD:
            begin
                txd_nxt = head_sel ? {FRAME_HEAD3, FRAME_HEAD2} : {FRAME_HEAD1, FRAME_HEAD0};
                if (head_sel)
                    state_nxt = SIGN;
            end
            SIGN:
            begin
                txd_nxt   = {(last_frame ? FILE_END : 8'h00), TX_IND};
                state_nxt = FNUM;
            end
            FNUM:
            begin
                txd_nxt   = frame_cnt;
                state_nxt = DLEN;
            end
            DLEN:
            begin
                txd_nxt   = valid_dlen;
                state_nxt = (data_words == '0) ? CHECK : DATA;
            end
            DATA:
            begin
                txd_nxt = i_rd_word;
                if (data_cnt == data_words - 1'b1)
                    state_nxt = CHECK;
            end
            CHECK:
            begin
                txd_nxt   = chk_cnt;
                state_nxt = EOF;
            end
            EOF:
            begin
                txd_nxt    = EOF_WORD;
                tk_msb_nxt = 1'b1;
                tk_lsb_nxt = 1'b1;
                state_nxt  = GAP;
            end
            default:
                state_nxt = IDLE;
        endcase
        // any mode other than normal takes the line away from the framer
        if (state != IDLE && i_tx_mode != MODE_NORM)
            state_nxt = IDLE;
    end

    //////////////////////////////////////////////////
    // registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (i_soft_reset)
        begin
            state          <= IDLE;
            o_txd          <= '0;
            o_tk_msb       <= 1'b0;
            o_tk_lsb       <= 1'b0;
            irq_dly        <= '0;
            o_tx_interrupt <= 1'b0;
        end
        else
        begin
            state    <= state_nxt;
            o_txd    <= txd_nxt;
            o_tk_msb <= tk_msb_nxt;
            o_tk_lsb <= tk_lsb_nxt;
            // delayed to land one cycle after the last gap word on the pins
            irq_dly        <= {irq_dly[0], gap_done & last_frame};
            o_tx_interrupt <= irq_dly[1];
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_soft_reset)
        begin
            frame_cnt  <= '0;
            sync_cnt   <= '0;
            gap_cnt    <= '0;
            data_cnt   <= '0;
            chk_cnt    <= '0;
            head_sel   <= 1'b0;
            last_frame <= 1'b0;
        end
        else
        begin
            case (state)
                BEGIN:
                begin
                    frame_cnt <= '0;
                    sync_cnt  <= '0;
                end
                SYNC:
                    sync_cnt <= sync_cnt + 1'b1;
                WAIT_DATA:
                begin
                    valid_dlen <= next_dlen;
                    last_frame <= next_last;
                end
                SOF:
                begin
                    head_sel <= 1'b0;
                    chk_cnt  <= '0;
                end
                HEAD:
                    head_sel <= ~head_sel;
                SIGN, FNUM:
                    chk_cnt <= chk_cnt + 16'd2;
                DLEN:
                begin
                    chk_cnt  <= chk_cnt + 16'd2;
                    data_cnt <= '0;
                end
                DATA:
                begin
                    chk_cnt  <= chk_cnt + 16'd2;
                    data_cnt <= data_cnt + 1'b1;
                end
                EOF:
                begin
                    frame_cnt <= frame_cnt + 1'b1;
                    gap_cnt   <= '0;
                end
                GAP:
                    gap_cnt <= gap_cnt + 1'b1;
                default:
                    chk_cnt <= chk_cnt;
            endcase
        end
    end

endmodule

// File: hdl/tx_mode_ctrl.sv
// TLK2711 mode control
`timescale 1ns/100ps

module tx_mode_ctrl
(
    input  logic                     clk,
    input  logic                     i_soft_reset,
    input  tlk_line_pkg::tx_mode_e   i_tx_mode,
    input  logic                     i_tx_start,
    input  tlk_line_pkg::line_word_t i_frm_txd,
    input  logic                     i_frm_tk_msb,
    input  logic                     i_frm_tk_lsb,
    output tlk_line_pkg::tx_mode_e   o_tx_mode,
    output tlk_line_pkg::line_word_t o_txd,
    output logic                     o_tk_msb,
    output logic                     o_tk_lsb,
    output logic                     o_enable,
    output logic                     o_loopen,
    output logic                     o_lckrefn
);

    import tlk_line_pkg::*;

    typedef enum logic [1:0] {PAT_COMMA1, PAT_COMMA2, PAT_SOF, PAT_COUNT} pat_state_e;

    tx_mode_e   tx_mode;
    pat_state_e pat_state;
    logic [4:0] pat_cnt;
    logic       pattern_mode;
    line_word_t pat_word;
    logic       pat_tk_msb;
    logic       pat_tk_lsb;

    assign o_tx_mode    = tx_mode;
    assign pattern_mode = (tx_mode == MODE_LOOPBACK) || (tx_mode == MODE_TEST);

    //////////////////////////////////////////////////
    // mode latch and chip pins
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (i_soft_reset)
        begin
            tx_mode   <= MODE_NORM;
            o_enable  <= 1'b0;
            o_loopen  <= 1'b0;
            o_lckrefn <= 1'b0;
        end
        else
        begin
            if (i_tx_start)
                tx_mode <= i_tx_mode;
            o_enable  <= 1'b1;
            o_lckrefn <= 1'b1;
            // internal chip loopback only
            o_loopen  <= (tx_mode == MODE_LOOPBACK);
        end
    end

    //////////////////////////////////////////////////
    // test pattern
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (i_soft_reset || i_tx_start)
        begin
            pat_state <= PAT_COMMA1;
            pat_cnt   <= '0;
        end
        else if (pattern_mode)
        begin
            case (pat_state)
                PAT_COMMA1: pat_state <= PAT_COMMA2;
                PAT_COMMA2: pat_state <= PAT_SOF;
                PAT_SOF:    pat_state <= PAT_COUNT;
                default:    pat_cnt   <= pat_cnt + 1'b1;
            endcase
        end
    end

    always_comb
    begin
        pat_word   = {3'b000, pat_cnt, 3'b000, pat_cnt};
        pat_tk_msb = 1'b0;
        pat_tk_lsb = 1'b0;
        case (pat_state)
            PAT_COMMA1, PAT_COMMA2:
            begin
                pat_word   = COMMA_WORD;
                pat_tk_lsb = 1'b1;
            end
            PAT_SOF:
            begin
                pat_word   = SOF_WORD;
                pat_tk_msb = 1'b1;
                pat_tk_lsb = 1'b1;
            end
            default:
                pat_word = {3'b000, pat_cnt, 3'b000, pat_cnt};
        endcase
    end

    //////////////////////////////////////////////////
    // line output select
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (i_soft_reset)
        begin
            o_txd    <= '0;
            o_tk_msb <= 1'b0;
            o_tk_lsb <= 1'b0;
        end
        else if (pattern_mode)
        begin
            o_txd    <= pat_word;
            o_tk_msb <= pat_tk_msb;
            o_tk_lsb <= pat_tk_lsb;
        end
        else if (tx_mode == MODE_KCODE)
        begin
            o_txd    <= SOF_WORD;
            o_tk_msb <= 1'b1;
            o_tk_lsb <= 1'b1;
        end
        else
        begin
            o_txd    <= i_frm_txd;
            o_tk_msb <= i_frm_tk_msb;
            o_tk_lsb <= i_frm_tk_lsb;
        end
    end

endmodule

// File: hdl/tlk2711_tx_top.sv
// TLK2711 transmit top
`timescale 1ns/100ps

module tlk2711_tx_top
#(
    parameter int DATA_WIDTH  = 64,
    parameter int FIFO_DEPTH  = 512,
    parameter int SYNC_CYCLES = 100000,
    parameter int GAP_CYCLES  = 257
)
(
    input  logic                     clk,
    input  logic                     i_soft_reset,
    input  tlk_line_pkg::tx_mode_e   i_tx_mode,
    input  logic                     i_tx_start,
    input  tx_frame_pkg::byte_len_t  i_tx_packet_body,
    input  tx_frame_pkg::byte_len_t  i_tx_packet_tail,
    input  tx_frame_pkg::frame_num_t i_tx_body_num,
    input  logic                     i_dma_valid,
    input  logic [DATA_WIDTH-1:0]    i_dma_data,
    output logic                     o_dma_credit,
    output logic                     o_tx_interrupt,
    output tlk_line_pkg::line_word_t o_txd,
    output logic                     o_tk_msb,
    output logic                     o_tk_lsb,
    output logic                     o_enable,
    output logic                     o_loopen,
    output logic                     o_lckrefn
);

    import tlk_line_pkg::*;

    line_level_t line_level;
    line_word_t  rd_word;
    logic        rd_en;
    line_word_t  frm_txd;
    logic        frm_tk_msb;
    logic        frm_tk_lsb;
    tx_mode_e    tx_mode;

    // writes are never refused, the source holds credits
    tx_gearbox_fifo
    #(
        .DATA_WIDTH   (DATA_WIDTH),
        .FIFO_DEPTH   (FIFO_DEPTH)
    )
    u_fifo
    (
        .clk          (clk),
        .i_soft_reset (i_soft_reset),
        .i_wr_en      (i_dma_valid),
        .i_wr_data    (i_dma_data),
        .i_rd_en      (rd_en),
        .o_rd_word    (rd_word),
        .o_line_level (line_level),
        .o_credit     (o_dma_credit)
    );

    tx_framer
    #(
        .SYNC_CYCLES      (SYNC_CYCLES),
        .GAP_CYCLES       (GAP_CYCLES)
    )
    u_framer
    (
        .clk              (clk),
        .i_soft_reset     (i_soft_reset),
        .i_tx_mode        (tx_mode),
        .i_tx_start       (i_tx_start),
        .i_tx_packet_body (i_tx_packet_body),
        .i_tx_packet_tail (i_tx_packet_tail),
        .i_tx_body_num    (i_tx_body_num),
        .i_line_level     (line_level),
        .i_rd_word        (rd_word),
        .o_rd_en          (rd_en),
        .o_txd            (frm_txd),
        .o_tk_msb         (frm_tk_msb),
        .o_tk_lsb         (frm_tk_lsb),
        .o_tx_interrupt   (o_tx_interrupt)
    );

    tx_mode_ctrl u_mode_ctrl
    (
        .clk          (clk),
        .i_soft_reset (i_soft_reset),
        .i_tx_mode    (i_tx_mode),
        .i_tx_start   (i_tx_start),
        .i_frm_txd    (frm_txd),
        .i_frm_tk_msb (frm_tk_msb),
        .i_frm_tk_lsb (frm_tk_lsb),
        .o_tx_mode    (tx_mode),
        .o_txd        (o_txd),
        .o_tk_msb     (o_tk_msb),
        .o_tk_lsb     (o_tk_lsb),
        .o_enable     (o_enable),
        .o_loopen     (o_loopen),
        .o_lckrefn    (o_lckrefn)
    );

endmodule

// File: tests/tb_tx_model.svh
// TX line stream reference
`ifndef TB_TX_MODEL_SVH
`define TB_TX_MODEL_SVH

// one expected line word with its K flags, {tk_msb, tk_lsb, txd}
function automatic logic [17:0] line_entry(input logic msb, input logic lsb,
                                           input logic [15:0] word);
    return {msb, lsb, word};
endfunction

// expected words of a whole file: frames, each followed by its gap commas
function automatic void model_file(input int body_num, input int body_len,
                                   input int tail_len);
    int         len;
    int         words;
    int         b;
    logic [7:0] sign;
    b = 0;
    for (int f = 0; f <= body_num; f++)
    begin
        len   = (f == body_num) ? tail_len : body_len;
        words = len / 2;
        sign  = (f == body_num) ? 8'h01 : 8'h00;
        exp_q.push_back(line_entry(1'b1, 1'b1, 16'h5CFB));
        exp_q.push_back(line_entry(1'b0, 1'b0, 16'hE116));
        exp_q.push_back(line_entry(1'b0, 1'b0, 16'hEB90));
        exp_q.push_back(line_entry(1'b0, 1'b0, {sign, 8'h81}));
        exp_q.push_back(line_entry(1'b0, 1'b0, 16'(f)));
        exp_q.push_back(line_entry(1'b0, 1'b0, 16'(len)));
        // incrementing byte pattern, low byte first on the line
        for (int j = 0; j < words; j++)
        begin
            exp_q.push_back(line_entry(1'b0, 1'b0, {8'(b + 1), 8'(b)}));
            b = b + 2;
        end
        // bytes from the sign word through the data
        exp_q.push_back(line_entry(1'b0, 1'b0, 16'(2 * (3 + words))));
        exp_q.push_back(line_entry(1'b1, 1'b1, 16'hFDFE));
        for (int g = 0; g < GAP_CYCLES; g++)
            exp_q.push_back(line_entry(1'b0, 1'b1, 16'hC5BC));
    end
endfunction

// loopback and chip-test pattern, word k counted from start
function automatic logic [17:0] pattern_word(input int k);
    logic [4:0] c;
    c = 5'((k - 3) % 32);
    if (k < 2)
        return line_entry(1'b0, 1'b1, 16'hC5BC);
    else if (k == 2)
        return line_entry(1'b1, 1'b1, 16'h5CFB);
    else
        return line_entry(1'b0, 1'b0, {3'b000, c, 3'b000, c});
endfunction

`endif

// File: tests/tb_tlk2711_tx.sv
// TLK2711 TX testbench
`timescale 1ns/100ps

module tb_tlk2711_tx;

    import tlk_line_pkg::*;
    import tx_frame_pkg::*;

    localparam int DATA_WIDTH  = 64;
    localparam int FIFO_DEPTH  = 16;
    localparam int SYNC_CYCLES = 20;
    localparam int GAP_CYCLES  = 8;
    localparam int TIMEOUT     = 20000;
    localparam logic [17:0] SOF_ENTRY   = {2'b11, 16'h5CFB};
    localparam logic [17:0] COMMA_ENTRY = {2'b01, 16'hC5BC};

    logic                  clk;
    logic                  soft_reset;
    tx_mode_e              tx_mode;
    logic                  tx_start;
    byte_len_t             packet_body;
    byte_len_t             packet_tail;
    frame_num_t            body_num;
    logic                  dma_valid;
    logic [DATA_WIDTH-1:0] dma_data;
    logic                  dma_credit;
    logic                  tx_interrupt;
    line_word_t            txd;
    logic                  tk_msb;
    logic                  tk_lsb;
    logic                  enable;
    logic                  loopen;
    logic                  lckrefn;

    logic [17:0] exp_q[$];
    int          err_cnt;
    int          credits;
    int          credits_back;
    int          words_sent;
    logic        check_en;
    logic        irq_due;
    logic        irq_seen;
    logic        abort_feed;

    `include "tb_tx_model.svh"

    tlk2711_tx_top
    #(
        .DATA_WIDTH  (DATA_WIDTH),
        .FIFO_DEPTH  (FIFO_DEPTH),
        .SYNC_CYCLES (SYNC_CYCLES),
        .GAP_CYCLES  (GAP_CYCLES)
    )
    uut
    (
        .clk              (clk),
        .i_soft_reset     (soft_reset),
        .i_tx_mode        (tx_mode),
        .i_tx_start       (tx_start),
        .i_tx_packet_body (packet_body),
        .i_tx_packet_tail (packet_tail),
        .i_tx_body_num    (body_num),
        .i_dma_valid      (dma_valid),
        .i_dma_data       (dma_data),
        .o_dma_credit     (dma_credit),
        .o_tx_interrupt   (tx_interrupt),
        .o_txd            (txd),
        .o_tk_msb         (tk_msb),
        .o_tk_lsb         (tk_lsb),
        .o_enable         (enable),
        .o_loopen         (loopen),
        .o_lckrefn        (lckrefn)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // DMA credit counter
    //////////////////////////////////////////////////

    initial
        credits_back = 0;

    always @(posedge clk)
    begin
        if (soft_reset)
            credits <= FIFO_DEPTH;
        else
        begin
            if (credits + int'(dma_credit) - int'(dma_valid) < 0 ||
                credits + int'(dma_credit) - int'(dma_valid) > FIFO_DEPTH)
            begin
                err_cnt++;
                $display("credit count out of range at %0t", $time);
            end
            credits <= credits + int'(dma_credit) - int'(dma_valid);
            if (dma_credit)
                credits_back <= credits_back + 1;
        end
    end

    //////////////////////////////////////////////////
    // line comparator
    //////////////////////////////////////////////////

    always @(negedge clk)
    begin : compare_line
        logic [17:0] obs;
        obs = {tk_msb, tk_lsb, txd};
        if (!check_en)
        begin
            irq_due  <= 1'b0;
            irq_seen <= 1'b0;
        end
        else
        begin
            if (tx_interrupt !== irq_due)
            begin
                err_cnt++;
                $display("[ERROR] o_tx_interrupt expected %h got %h", irq_due, tx_interrupt);
            end
            if (tx_interrupt)
                irq_seen <= 1'b1;
            irq_due <= 1'b0;
            if (exp_q.size() > 0)
            begin
                // commas and idle words ahead of a frame are skipped
                if (exp_q[0] == SOF_ENTRY && obs != SOF_ENTRY)
                begin
                    if (obs != COMMA_ENTRY && obs != 18'h0)
                    begin
                        err_cnt++;
                        $display("[ERROR] {o_tk_msb,o_tk_lsb,o_txd} expected %h got %h",
                                 SOF_ENTRY, obs);
                    end
                end
                else
                begin
                    if (obs !== exp_q[0])
                    begin
                        err_cnt++;
                        $display("[ERROR] {o_tk_msb,o_tk_lsb,o_txd} expected %h got %h",
                                 exp_q[0], obs);
                    end
                    void'(exp_q.pop_front());
                    if (exp_q.size() == 0)
                        irq_due <= 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // tasks
    //////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            err_cnt++;
            $display("[ERROR] %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic check_idle_pins();
        check_value("o_enable", enable, 0);
        check_value("o_loopen", loopen, 0);
        check_value("o_lckrefn", lckrefn, 0);
        check_value("o_tk_msb", tk_msb, 0);
        check_value("o_tk_lsb", tk_lsb, 0);
        check_value("o_txd", txd, 0);
        check_value("o_tx_interrupt", tx_interrupt, 0);
        check_value("o_dma_credit", dma_credit, 0);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        soft_reset <= 1'b1;
        tx_start   <= 1'b0;
        dma_valid  <= 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_idle_pins();
        @(posedge clk);
        soft_reset <= 1'b0;
        @(negedge clk);
        check_idle_pins();
        @(negedge clk);
        check_value("o_enable", enable, 1);
        check_value("o_lckrefn", lckrefn, 1);
        check_value("o_loopen", loopen, 0);
    endtask

    task automatic pulse_start(input tx_mode_e mode);
        @(posedge clk);
        tx_mode  <= mode;
        tx_start <= 1'b1;
        @(posedge clk);
        tx_start <= 1'b0;
    endtask

    // source side with one 64-bit word per credit
    task automatic feed_dma(input int total, input bit stall_en);
        int                    sent;
        int                    timer;
        logic [DATA_WIDTH-1:0] w;
        sent  = 0;
        timer = 0;
        while (sent < total && !abort_feed && timer < TIMEOUT)
        begin
            @(posedge clk);
            if (!(stall_en && ($urandom % 3 == 0)) && credits - int'(dma_valid) > 0)
            begin
                for (int i = 0; i < 8; i++)
                    w[8*i +: 8] = 8'(8 * sent + i);
                dma_valid <= 1'b1;
                dma_data  <= w;
                sent++;
                words_sent++;
                timer = 0;
            end
            else
            begin
                dma_valid <= 1'b0;
                timer++;
            end
        end
        @(posedge clk);
        dma_valid <= 1'b0;
        if (timer >= TIMEOUT)
        begin
            err_cnt++;
            $display("DMA source ran out of credits and timed out");
        end
    endtask

    task automatic wait_file_done();
        int timer;
        timer = 0;
        while (!irq_seen && timer < TIMEOUT)
        begin
            @(negedge clk);
            timer++;
        end
        if (!irq_seen)
        begin
            err_cnt++;
            $display("no transmit interrupt before timeout");
        end
        if (exp_q.size() != 0)
        begin
            err_cnt++;
            $display("file ended with %0d line words still expected", exp_q.size());
        end
    endtask

    task automatic setup_file(input int bn, input int bl, input int tl);
        check_en = 1'b0;
        abort_feed = 1'b0;
        @(negedge clk);
        exp_q.delete();
        model_file(bn, bl, tl);
        @(posedge clk);
        body_num    <= 16'(bn);
        packet_body <= 16'(bl);
        packet_tail <= 16'(tl);
        check_en = 1'b1;
        pulse_start(MODE_NORM);
    endtask

    task automatic run_file(input int bn, input int bl, input int tl, input bit stall_en);
        int back0;
        int sent0;
        int total;
        back0 = credits_back;
        sent0 = words_sent;
        total = (bn * bl + tl) / 8;
        setup_file(bn, bl, tl);
        fork
            feed_dma(total, stall_en);
            wait_file_done();
        join
        repeat (2) @(negedge clk);
        check_value("credits returned", credits_back - back0, words_sent - sent0);
        check_value("source credits", credits, FIFO_DEPTH);
        check_en = 1'b0;
    endtask

    task automatic check_pattern(input tx_mode_e mode, input int n);
        int          timer;
        logic [17:0] exp;
        timer = 0;
        pulse_start(mode);
        @(negedge clk);
        while ({tk_msb, tk_lsb, txd} != COMMA_ENTRY && timer < TIMEOUT)
        begin
            @(negedge clk);
            timer++;
        end
        if (timer >= TIMEOUT)
        begin
            err_cnt++;
            $display("test pattern never started");
        end
        for (int k = 0; k < n; k++)
        begin
            exp = pattern_word(k);
            check_value("{o_tk_msb,o_tk_lsb,o_txd}", {tk_msb, tk_lsb, txd}, exp);
            check_value("o_loopen", loopen, (mode == MODE_LOOPBACK));
            @(negedge clk);
        end
    endtask

    //////////////////////////////////////////////////
    // scenarios
    //////////////////////////////////////////////////

    initial
    begin : scenarios
        int timer;
        int size0;
        void'($urandom(18));
        err_cnt     = 0;
        words_sent  = 0;
        check_en    = 1'b0;
        abort_feed  = 1'b0;
        soft_reset  = 1'b1;
        tx_mode     = MODE_NORM;
        tx_start    = 1'b0;
        packet_body = '0;
        packet_tail = '0;
        body_num    = '0;
        dma_valid   = 1'b0;
        dma_data    = '0;

        apply_reset();
        run_file(0, 64, 32, 1'b0);
        run_file(2, 64, 16, 1'b0);
        run_file(2, 128, 24, 1'b1);

        // loopback pattern then constant SOF
        apply_reset();
        check_pattern(MODE_LOOPBACK, 40);
        apply_reset();
        // kcode has no comma lead-in
        pulse_start(MODE_KCODE);
        repeat (3) @(negedge clk);
        for (int k = 0; k < 20; k++)
        begin
            check_value("{o_tk_msb,o_tk_lsb,o_txd}", {tk_msb, tk_lsb, txd}, SOF_ENTRY);
            check_value("o_loopen", loopen, 0);
            @(negedge clk);
        end
        apply_reset();

        // reset in the middle of a frame
        setup_file(1, 64, 32);
        size0 = exp_q.size();
        fork
            feed_dma((64 + 32) / 8, 1'b0);
            begin
                timer = 0;
                while (exp_q.size() > size0 - 12 && timer < TIMEOUT)
                begin
                    @(negedge clk);
                    timer++;
                end
                if (timer >= TIMEOUT)
                begin
                    err_cnt++;
                    $display("first frame did not start before timeout");
                end
                check_en   = 1'b0;
                abort_feed = 1'b1;
            end
        join
        apply_reset();
        run_file(1, 64, 32, 1'b0);

        $display("errors: %0d", err_cnt);
        if (err_cnt == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+tests
common/tlk_line_pkg.sv
common/tx_frame_pkg.sv
hdl/tx_gearbox_fifo.sv
tx_framer/tx_framer.sv
hdl/tx_mode_ctrl.sv
hdl/tlk2711_tx_top.sv
tests/tb_tlk2711_tx.sv
